// File: build.f
src/layers_pkg.sv
src/layers_if.sv
src/layers_control.sv
src/layers_dot.sv
src/layers_mac.sv
src/layers_post.sv
src/layers.sv
testbench/layers_checker.sv
testbench/layers_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the layers testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module layers_tb -f build.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/Vlayers_tb)
echo "$sim_out"

echo "$sim_out" | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/layers.sv
`timescale 1ns/10ps

module layers #(
    parameter int CFG_DWIDTH = 32,
    parameter int CFG_AWIDTH = 5,
    parameter int DEPTH_NB   = 16,
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int KER_WIDTH  = 16
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [CFG_DWIDTH-1:0]                  cfg_data,
    input  logic [CFG_AWIDTH-1:0]                  cfg_addr,
    input  logic                                   cfg_valid,
    input  logic [DEPTH_NB*KER_WIDTH-1:0]          bias_bus,
    input  logic [GROUP_NB*KER_WIDTH*DEPTH_NB-1:0] kernel_bus,
    output logic                                   kernel_rdy,
    input  logic [GROUP_NB*IMG_WIDTH-1:0]          image_bus,
    input  logic                                   image_last,
    input  logic                                   image_val,
    output logic                                   image_rdy,
    output logic [IMG_WIDTH*DEPTH_NB-1:0]          result_bus,
    output logic                                   result_val,
    input  logic                                   result_rdy
);
    layers_pkg::layer_cfg_t layer_cfg;

    layers_beat_if #(
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) beat_if ();

    layers_acc_if #(
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) acc_if ();

    layers_control #(
        .CFG_DWIDTH (CFG_DWIDTH), .CFG_AWIDTH (CFG_AWIDTH),
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) u_control (
        .clk (clk), .reset (reset),
        .cfg_data (cfg_data), .cfg_addr (cfg_addr), .cfg_valid (cfg_valid),
        .kernel_bus (kernel_bus), .image_bus (image_bus),
        .image_last (image_last), .image_val (image_val),
        .image_rdy (image_rdy), .kernel_rdy (kernel_rdy),
        .beat (beat_if), .acc (acc_if), .cfg (layer_cfg)
    );

    layers_mac #(
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) u_mac (
        .clk (clk), .reset (reset), .bias_bus (bias_bus), .cfg (layer_cfg),
        .beat (beat_if), .acc (acc_if)
    );

    layers_post #(
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) u_post (
        .clk (clk), .reset (reset), .acc (acc_if),
        .result_bus (result_bus), .result_val (result_val), .result_rdy (result_rdy)
    );

endmodule

// File: src/layers_control.sv
`timescale 1ns/10ps

module layers_control #(
    parameter int CFG_DWIDTH = 32,
    parameter int CFG_AWIDTH = 5,
    parameter int DEPTH_NB   = 16,
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int KER_WIDTH  = 16
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [CFG_DWIDTH-1:0]                  cfg_data,
    input  logic [CFG_AWIDTH-1:0]                  cfg_addr,
    input  logic                                   cfg_valid,
    input  logic [GROUP_NB*KER_WIDTH*DEPTH_NB-1:0] kernel_bus,
    input  logic [GROUP_NB*IMG_WIDTH-1:0]          image_bus,
    input  logic                                   image_last,
    input  logic                                   image_val,
    output logic                                   image_rdy,
    output logic                                   kernel_rdy,
    layers_beat_if.source                          beat,
    layers_acc_if.monitor                          acc,
    output layers_pkg::layer_cfg_t                 cfg
);
    layers_pkg::ctrl_state_e state;
    logic                    accept;
    logic                    flush_done;
    logic                    first_pending;
    logic                    cfg_write;

    assign accept     = image_val && image_rdy;
    assign flush_done = acc.val && acc.rdy;
    assign cfg_write  = cfg_valid && (cfg_addr == CFG_AWIDTH'(layers_pkg::CFG_LAYERS));
    assign image_rdy  = (state == layers_pkg::ST_ACCUM);

    // frame state machine, no new beats until the sum vector has left the mac
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= layers_pkg::ST_IDLE;
            first_pending <= 1'b1;
            kernel_rdy    <= 1'b0;
            beat.en       <= 1'b0;
        end else begin
            case (state)
                layers_pkg::ST_IDLE: state <= layers_pkg::ST_ACCUM;
                layers_pkg::ST_ACCUM: begin
                    if (accept && image_last) begin
                        state <= layers_pkg::ST_FLUSH;
                    end
                end
                layers_pkg::ST_FLUSH: begin
                    if (flush_done) begin
                        state <= layers_pkg::ST_ACCUM;
                    end
                end
                default: state <= layers_pkg::ST_IDLE;
            endcase
            // next frame starts after a last beat
            if (accept) begin
                first_pending <= image_last;
            end
            kernel_rdy <= accept;
            beat.en    <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat.image  <= image_bus;
            beat.kernel <= kernel_bus;
            beat.first  <= first_pending;
            beat.last   <= image_last;
        end
    end

    // layer register
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.relu      <= 1'b0;
            cfg.pool_size <= 8'd1;
            cfg.shift     <= 8'd0;
        end else if (cfg_write) begin
            cfg.relu      <= cfg_data[layers_pkg::CFG_RELU_BIT];
            cfg.pool_size <= cfg_data[layers_pkg::CFG_POOL_LSB +: 8];
            cfg.shift     <= cfg_data[layers_pkg::CFG_SHIFT_LSB +: 8];
        end
    end

endmodule

// File: src/layers_dot.sv
`timescale 1ns/10ps

module layers_dot #(
    parameter int GROUP_NB  = 4,
    parameter int IMG_WIDTH = 16,
    parameter int KER_WIDTH = 16
) (
    input  logic [GROUP_NB*IMG_WIDTH-1:0]                      image,
    input  logic [GROUP_NB*KER_WIDTH-1:0]                      kernel,
    output logic signed [IMG_WIDTH+KER_WIDTH+$clog2(GROUP_NB+1):0] sum
);
    localparam int PROD_WIDTH = IMG_WIDTH + KER_WIDTH;

    logic signed [PROD_WIDTH-1:0] prod [GROUP_NB];

    // pixel by weight, both signed
    always_comb begin
        for (int g = 0; g < GROUP_NB; g++) begin
            prod[g] = $signed(image[g*IMG_WIDTH +: IMG_WIDTH])
                    * $signed(kernel[g*KER_WIDTH +: KER_WIDTH]);
        end
    end

    always_comb begin
        sum = '0;
        for (int g = 0; g < GROUP_NB; g++) begin
            sum = sum + prod[g];
        end
    end

endmodule

// File: src/layers_if.sv
`timescale 1ns/10ps

// one accepted image beat, registered by control
interface layers_beat_if #(
    parameter int DEPTH_NB  = 16,
    parameter int GROUP_NB  = 4,
    parameter int IMG_WIDTH = 16,
    parameter int KER_WIDTH = 16
);
    logic                                   en;
    logic                                   first;
    logic                                   last;
    logic [GROUP_NB*IMG_WIDTH-1:0]          image;
    logic [GROUP_NB*KER_WIDTH*DEPTH_NB-1:0] kernel;

    modport source (output en, first, last, image, kernel);
    modport sink   (input en, first, last, image, kernel);
endinterface

// finished sum vector, valid/ready hand-off from mac to post
interface layers_acc_if #(
    parameter int DEPTH_NB  = 16,
    parameter int GROUP_NB  = 4,
    parameter int IMG_WIDTH = 16,
    parameter int KER_WIDTH = 16
);
    localparam int ACC_WIDTH = IMG_WIDTH + KER_WIDTH + 1 + $clog2(GROUP_NB + 1);

    logic [DEPTH_NB*ACC_WIDTH-1:0] acc;
    layers_pkg::layer_cfg_t        cfg;
    logic                          val;
    logic                          rdy;

    modport source  (output acc, cfg, val, input rdy);
    modport sink    (input acc, cfg, val, output rdy);
    // control only watches the hand-off to leave the flush state
    modport monitor (input val, rdy);
endinterface

// File: src/layers_mac.sv
`timescale 1ns/10ps

module layers_mac #(
    parameter int DEPTH_NB  = 16,
    parameter int GROUP_NB  = 4,
    parameter int IMG_WIDTH = 16,
    parameter int KER_WIDTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [DEPTH_NB*KER_WIDTH-1:0] bias_bus,
    input  layers_pkg::layer_cfg_t        cfg,
    layers_beat_if.sink                   beat,
    layers_acc_if.source                  acc
);
    localparam int ACC_WIDTH   = IMG_WIDTH + KER_WIDTH + 1 + $clog2(GROUP_NB + 1);
    localparam int SLICE_WIDTH = GROUP_NB * KER_WIDTH;

    logic [DEPTH_NB*KER_WIDTH-1:0] bias_q;
    logic signed [ACC_WIDTH-1:0]   dot_sum [DEPTH_NB];
    logic signed [ACC_WIDTH-1:0]   acc_q [DEPTH_NB];

    for (genvar d = 0; d < DEPTH_NB; d++) begin : g_depth
        layers_dot #(
            .GROUP_NB  (GROUP_NB),
            .IMG_WIDTH (IMG_WIDTH),
            .KER_WIDTH (KER_WIDTH)
        ) u_dot (
            .image  (beat.image),
            .kernel (beat.kernel[d*SLICE_WIDTH +: SLICE_WIDTH]),
            .sum    (dot_sum[d])
        );
    end

    // bias taken on the accept edge, used while en is high
    always_ff @(posedge clk) begin
        bias_q <= bias_bus;
    end

    always_ff @(posedge clk) begin
        if (beat.en) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                if (beat.first) begin
                    acc_q[d] <= $signed(bias_q[d*KER_WIDTH +: KER_WIDTH]) + dot_sum[d];
                end else begin
                    acc_q[d] <= acc_q[d] + dot_sum[d];
                end
            end
        end
    end

    // sum vector is offered once the last beat has been added
    always_ff @(posedge clk) begin
        if (reset) begin
            acc.val <= 1'b0;
        end else if (beat.en && beat.last) begin
            acc.val <= 1'b1;
        end else if (acc.rdy) begin
            acc.val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.en && beat.last) begin
            acc.cfg <= cfg;
        end
    end

    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            acc.acc[d*ACC_WIDTH +: ACC_WIDTH] = acc_q[d];
        end
    end

endmodule

// File: src/layers_pkg.sv
package layers_pkg;

    // configuration register map, one register for now
    typedef enum logic [4:0] {
        CFG_LAYERS = 5'd0,
        CFG_NONE   = 5'd31
    } cfg_addr_e;

    // frame control states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCUM,
        ST_FLUSH
    } ctrl_state_e;

    // layer register contents
    typedef struct packed {
        logic       relu;
        logic [7:0] pool_size;
        logic [7:0] shift;
    } layer_cfg_t;

    // field positions inside cfg_data
    localparam int CFG_RELU_BIT  = 16;
    localparam int CFG_POOL_LSB  = 8;
    localparam int CFG_SHIFT_LSB = 0;

endpackage

// File: src/layers_post.sv
`timescale 1ns/10ps

module layers_post #(
    parameter int DEPTH_NB  = 16,
    parameter int GROUP_NB  = 4,
    parameter int IMG_WIDTH = 16,
    parameter int KER_WIDTH = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    layers_acc_if.sink                    acc,
    output logic [IMG_WIDTH*DEPTH_NB-1:0] result_bus,
    output logic                          result_val,
    input  logic                          result_rdy
);
    localparam int ACC_WIDTH = IMG_WIDTH + KER_WIDTH + 1 + $clog2(GROUP_NB + 1);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
        (ACC_WIDTH'(1) << (IMG_WIDTH - 1)) - ACC_WIDTH'(1);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = ~SAT_MAX;

    logic                        capture;
    logic                        pool_done;
    logic [7:0]                  pool_size_eff;
    logic [7:0]                  pool_cnt;
    logic signed [ACC_WIDTH-1:0] shifted [DEPTH_NB];
    logic signed [ACC_WIDTH-1:0] rectified [DEPTH_NB];
    logic signed [IMG_WIDTH-1:0] clipped [DEPTH_NB];
    logic signed [IMG_WIDTH-1:0] pooled [DEPTH_NB];
    logic signed [IMG_WIDTH-1:0] pool_max [DEPTH_NB];

    // free to take a vector unless a result is still waiting
    assign acc.rdy = !result_val || result_rdy;
    assign capture = acc.val && acc.rdy;

    // pool size 0 behaves like 1
    assign pool_size_eff = (acc.cfg.pool_size == 8'd0) ? 8'd1 : acc.cfg.pool_size;
    assign pool_done     = (pool_cnt == pool_size_eff - 8'd1);

    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            shifted[d] = $signed(acc.acc[d*ACC_WIDTH +: ACC_WIDTH]) >>> acc.cfg.shift;
            // relu clamps negatives to zero
            if (acc.cfg.relu && shifted[d][ACC_WIDTH-1]) begin
                rectified[d] = '0;
            end else begin
                rectified[d] = shifted[d];
            end
            if (rectified[d] > SAT_MAX) begin
                clipped[d] = SAT_MAX[IMG_WIDTH-1:0];
            end else if (rectified[d] < SAT_MIN) begin
                clipped[d] = SAT_MIN[IMG_WIDTH-1:0];
            end else begin
                clipped[d] = rectified[d][IMG_WIDTH-1:0];
            end
            // first vector of a pool window starts the running max
            if (pool_cnt == 8'd0 || clipped[d] > pool_max[d]) begin
                pooled[d] = clipped[d];
            end else begin
                pooled[d] = pool_max[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_val <= 1'b0;
            pool_cnt   <= 8'd0;
        end else begin
            if (capture && pool_done) begin
                result_val <= 1'b1;
            end else if (result_rdy) begin
                result_val <= 1'b0;
            end
            if (capture) begin
                pool_cnt <= pool_done ? 8'd0 : pool_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                pool_max[d] <= pooled[d];
                if (pool_done) begin
                    result_bus[d*IMG_WIDTH +: IMG_WIDTH] <= pooled[d];
                end
            end
        end
    end

endmodule

// File: testbench/layers_checker.sv
`timescale 1ns/10ps

module layers_checker #(
    parameter int CFG_DWIDTH = 32,
    parameter int CFG_AWIDTH = 5,
    parameter int DEPTH_NB   = 4,
    parameter int GROUP_NB   = 2,
    parameter int IMG_WIDTH  = 8,
    parameter int KER_WIDTH  = 8
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [CFG_DWIDTH-1:0]                  cfg_data,
    input  logic [CFG_AWIDTH-1:0]                  cfg_addr,
    input  logic                                   cfg_valid,
    input  logic [DEPTH_NB*KER_WIDTH-1:0]          bias_bus,
    input  logic [GROUP_NB*KER_WIDTH*DEPTH_NB-1:0] kernel_bus,
    input  logic                                   kernel_rdy,
    input  logic [GROUP_NB*IMG_WIDTH-1:0]          image_bus,
    input  logic                                   image_last,
    input  logic                                   image_val,
    input  logic                                   image_rdy,
    input  logic [IMG_WIDTH*DEPTH_NB-1:0]          result_bus,
    input  logic                                   result_val,
    input  logic                                   result_rdy,
    output int                                     value_errors,
    output int                                     protocol_errors,
    output int                                     pending,
    output int                                     beat_count,
    output int                                     pulse_count,
    output int                                     result_count
);
    localparam longint SAT_MAX = (longint'(1) <<< (IMG_WIDTH - 1)) - 1;
    localparam longint SAT_MIN = -(longint'(1) <<< (IMG_WIDTH - 1));

    logic [IMG_WIDTH*DEPTH_NB-1:0] expected_q [$];
    logic                          relu_q [$];
    longint                        acc_model [DEPTH_NB];
    logic signed [IMG_WIDTH-1:0]   pool_max [DEPTH_NB];
    logic                          relu;
    int                            pool_size;
    int                            shift;
    int                            pool_cnt;
    logic                          first_beat;
    logic                          accept_d;
    logic                          reset_d = 1'b0;
    logic                          stalled;
    logic [IMG_WIDTH*DEPTH_NB-1:0] stalled_bus;
    int                            n_value = 0;
    int                            n_protocol = 0;
    int                            n_beats = 0;
    int                            n_pulses = 0;
    int                            n_results = 0;
    int                            n_pending = 0;

    assign value_errors    = n_value;
    assign protocol_errors = n_protocol;
    assign pending         = n_pending;
    assign beat_count      = n_beats;
    assign pulse_count     = n_pulses;
    assign result_count    = n_results;

    // shift, relu, saturate and pool a finished dot product
    task automatic close_frame();
        longint                        v;
        logic signed [IMG_WIDTH-1:0]   c;
        logic [IMG_WIDTH*DEPTH_NB-1:0] packed_max;
        int                            eff;
        eff = (pool_size == 0) ? 1 : pool_size;
        for (int d = 0; d < DEPTH_NB; d++) begin
            v = acc_model[d] >>> shift;
            if (relu && v < 0) begin
                v = 0;
            end
            if (v > SAT_MAX) begin
                v = SAT_MAX;
            end else if (v < SAT_MIN) begin
                v = SAT_MIN;
            end
            c = IMG_WIDTH'(v);
            if (pool_cnt == 0 || c > pool_max[d]) begin
                pool_max[d] = c;
            end
            packed_max[d*IMG_WIDTH +: IMG_WIDTH] = pool_max[d];
        end
        pool_cnt++;
        if (pool_cnt >= eff) begin
            expected_q.push_back(packed_max);
            relu_q.push_back(relu);
            pool_cnt = 0;
        end
    endtask

    task automatic take_beat();
        longint px;
        longint wt;
        longint term;
        for (int d = 0; d < DEPTH_NB; d++) begin
            term = 0;
            for (int g = 0; g < GROUP_NB; g++) begin
                px = longint'($signed(image_bus[g*IMG_WIDTH +: IMG_WIDTH]));
                wt = longint'($signed(kernel_bus[(d*GROUP_NB + g)*KER_WIDTH +: KER_WIDTH]));
                term += px * wt;
            end
            // a frame starts from the bias of its first beat
            if (first_beat) begin
                acc_model[d] = longint'($signed(bias_bus[d*KER_WIDTH +: KER_WIDTH])) + term;
            end else begin
                acc_model[d] += term;
            end
        end
        first_beat = image_last;
        n_beats++;
        if (image_last) begin
            close_frame();
        end
    endtask

    task automatic check_result();
        logic [IMG_WIDTH*DEPTH_NB-1:0] exp;
        logic                          relu_on;
        n_results++;
        if (expected_q.size() == 0) begin
            n_protocol++;
            $display("result transfer at %0t with no result expected", $time);
        end else begin
            exp     = expected_q.pop_front();
            relu_on = relu_q.pop_front();
            if (result_bus !== exp) begin
                n_value++;
                $display("** Error result_bus: expected %h, got %h", exp, result_bus);
            end
            for (int d = 0; d < DEPTH_NB; d++) begin
                if (relu_on && result_bus[d*IMG_WIDTH + IMG_WIDTH - 1]) begin
                    n_value++;
                    $display("** Error result_bus[lane %0d]: expected non-negative, got %h",
                             d, result_bus[d*IMG_WIDTH +: IMG_WIDTH]);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (reset_d && (image_rdy || kernel_rdy || result_val)) begin
                n_protocol++;
                $display("outputs not low during reset at %0t", $time);
            end
            relu       = 1'b0;
            pool_size  = 1;
            shift      = 0;
            pool_cnt   = 0;
            first_beat = 1'b1;
            accept_d   = 1'b0;
            stalled    = 1'b0;
            expected_q.delete();
            relu_q.delete();
        end else begin
            // kernel_rdy answers each accepted beat one cycle later
            if (kernel_rdy !== accept_d) begin
                n_protocol++;
                $display("** Error kernel_rdy: expected %h, got %h", accept_d, kernel_rdy);
            end
            if (kernel_rdy) begin
                n_pulses++;
            end
            if (cfg_valid && cfg_addr == CFG_AWIDTH'(layers_pkg::CFG_LAYERS)) begin
                relu      = cfg_data[layers_pkg::CFG_RELU_BIT];
                pool_size = int'(cfg_data[layers_pkg::CFG_POOL_LSB +: 8]);
                shift     = int'(cfg_data[layers_pkg::CFG_SHIFT_LSB +: 8]);
            end
            accept_d = image_val && image_rdy;
            if (accept_d) begin
                take_beat();
            end
            if (stalled) begin
                if (!result_val) begin
                    n_protocol++;
                    $display("result_val dropped at %0t before the result was taken", $time);
                end else if (result_bus !== stalled_bus) begin
                    n_value++;
                    $display("** Error result_bus: changed while stalled, expected %h, got %h",
                             stalled_bus, result_bus);
                end
            end
            if (result_val && result_rdy) begin
                check_result();
            end
            stalled     = result_val && !result_rdy;
            stalled_bus = result_bus;
        end
        n_pending = expected_q.size();
        reset_d   = reset;
    end

endmodule

// File: testbench/layers_tb.sv
`timescale 1ns/10ps

module layers_tb;
    localparam int CFG_DWIDTH   = 32;
    localparam int CFG_AWIDTH   = 5;
    localparam int DEPTH_NB     = 4;
    localparam int GROUP_NB     = 2;
    localparam int IMG_WIDTH    = 8;
    localparam int KER_WIDTH    = 8;
    localparam int RESET_FRAMES = 8;
    localparam int SHIFT_FRAMES = 3;
    localparam int POOL_ROUNDS  = 3;
    // pool sizes 2, 3, 4 and 0 give 2+3+4+1 frames per round
    localparam int TOTAL_FRAMES = RESET_FRAMES + 9 * SHIFT_FRAMES + 10 * POOL_ROUNDS;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 20 + 1000;

    logic                                   clk;
    logic                                   reset;
    logic [CFG_DWIDTH-1:0]                  cfg_data;
    logic [CFG_AWIDTH-1:0]                  cfg_addr;
    logic                                   cfg_valid;
    logic [DEPTH_NB*KER_WIDTH-1:0]          bias_bus;
    logic [GROUP_NB*KER_WIDTH*DEPTH_NB-1:0] kernel_bus;
    logic                                   kernel_rdy;
    logic [GROUP_NB*IMG_WIDTH-1:0]          image_bus;
    logic                                   image_last;
    logic                                   image_val;
    logic                                   image_rdy;
    logic [IMG_WIDTH*DEPTH_NB-1:0]          result_bus;
    logic                                   result_val;
    logic                                   result_rdy;
    int value_errors;
    int protocol_errors;
    int pending;
    int beat_count;
    int pulse_count;
    int result_count;
    int expected_results = 0;
    int count_errors = 0;

    layers #(
        .CFG_DWIDTH (CFG_DWIDTH), .CFG_AWIDTH (CFG_AWIDTH),
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) UUT (.*);

    layers_checker #(
        .CFG_DWIDTH (CFG_DWIDTH), .CFG_AWIDTH (CFG_AWIDTH),
        .DEPTH_NB (DEPTH_NB), .GROUP_NB (GROUP_NB),
        .IMG_WIDTH (IMG_WIDTH), .KER_WIDTH (KER_WIDTH)
    ) checks (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // result side takes about three results in four cycles
    initial begin
        result_rdy = 1'b0;
        forever begin
            @(negedge clk);
            result_rdy = (($urandom % 4) != 0);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // called just after a falling edge, returns just after one
    task automatic send_beat(input logic last);
        while (($urandom % 4) == 0) begin
            @(negedge clk);
        end
        for (int g = 0; g < GROUP_NB; g++) begin
            image_bus[g*IMG_WIDTH +: IMG_WIDTH] = IMG_WIDTH'($urandom);
        end
        for (int k = 0; k < GROUP_NB * DEPTH_NB; k++) begin
            kernel_bus[k*KER_WIDTH +: KER_WIDTH] = KER_WIDTH'($urandom);
        end
        for (int d = 0; d < DEPTH_NB; d++) begin
            bias_bus[d*KER_WIDTH +: KER_WIDTH] = KER_WIDTH'($urandom);
        end
        image_last = last;
        image_val  = 1'b1;
        while (!image_rdy) begin
            @(negedge clk);
        end
        @(negedge clk);
        image_val = 1'b0;
    endtask

    task automatic run_frames(input int frames, input int pool_eff);
        int beats;
        for (int f = 0; f < frames; f++) begin
            beats = 1 + int'($urandom % 6);
            for (int b = 0; b < beats; b++) begin
                send_beat(b == beats - 1);
            end
        end
        expected_results += frames / pool_eff;
    endtask

    task automatic drain();
        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    // second write goes to an unused address and must be ignored
    task automatic write_layer(input logic relu, input logic [7:0] pool, input logic [7:0] shift);
        cfg_data        = '0;
        cfg_data[16]    = relu;
        cfg_data[15:8]  = pool;
        cfg_data[7:0]   = shift;
        cfg_addr        = layers_pkg::CFG_LAYERS;
        cfg_valid       = 1'b1;
        @(negedge clk);
        cfg_data  = $urandom;
        cfg_addr  = layers_pkg::CFG_NONE;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    initial begin
        int pool;
        void'($urandom(75790));
        reset      = 1'b1;
        cfg_data   = '0;
        cfg_addr   = '0;
        cfg_valid  = 1'b0;
        bias_bus   = '0;
        kernel_bus = '0;
        image_bus  = '0;
        image_last = 1'b0;
        image_val  = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // reset configuration: pool 1, shift 0, relu off
        run_frames(RESET_FRAMES, 1);
        drain();

        for (int s = 0; s <= 8; s++) begin
            write_layer(1'b1, 8'd1, 8'(s));
            run_frames(SHIFT_FRAMES, 1);
            drain();
        end

        for (int i = 0; i < 4; i++) begin
            pool = (i == 3) ? 0 : i + 2;
            write_layer(1'b0, 8'(pool), 8'd8);
            run_frames(POOL_ROUNDS * ((pool == 0) ? 1 : pool), (pool == 0) ? 1 : pool);
            drain();
        end

        repeat (4) @(negedge clk);
        if (pulse_count != beat_count) begin
            count_errors++;
            $display("kernel_rdy pulsed %0d times for %0d accepted beats", pulse_count, beat_count);
        end
        if (result_count != expected_results) begin
            count_errors++;
            $display("got %0d results where %0d were expected", result_count, expected_results);
        end
        $display("errors: value %0d, protocol %0d, count %0d (beats %0d, results %0d)",
                 value_errors, protocol_errors, count_errors, beat_count, result_count);
        if (value_errors + protocol_errors + count_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
